/* build.f */
+incdir+.
dsconv_types_pkg.sv
dsconv_coeff_pkg.sv
dsconv_ctrl.sv
dsconv_line_buffer.sv
dsconv_depthwise_pe.sv
dsconv_pointwise_pe.sv
dsconv_batch_norm.sv
dsconv_top.sv
tb_dsconv.sv

/* run.sh */
#!/bin/sh
# Compiles the testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_dsconv \
    -Mdir obj_dir -o tb_dsconv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dsconv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0

/* tb_dsconv.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dsconv_config.svh"

module tb_dsconv;
    import dsconv_types_pkg::*;

    localparam int PIXELS         = `DSCONV_IMG_W * `DSCONV_IMG_H;
    localparam int TOTAL_PIXELS   = PIXELS * `DSCONV_FILTERS;
    localparam int READY_PER_FILT = (`DSCONV_IMG_W - 2) * (`DSCONV_IMG_H - 2);
    localparam int TIMEOUT_CYCLES = 2000;    // Four frames, start gaps, reset and drain.

    logic            clk;
    logic            rst;
    logic            start;
    channel_pixels_t input_pixels;
    addr_t           input_pixel_addr;
    pixel_t          output_pixel;
    addr_t           output_pixel_addr;
    filter_t         output_filter;
    logic            ready;
    logic            done;

    channel_pixels_t image [PIXELS];
    int seed = 32'h6b043fba;

    // Model of the item pipeline with one entry per stage.
    logic mp_valid [4];
    int   mp_addr  [4];
    int   mp_filter [4];
    logic mp_gap   [4];

    int err_reset, err_framing, err_values, err_relu, err_gaps, err_done;
    int checks, consumed, gap_left, gap_runs, relu_hits, total_ready, done_count, cycles;
    int ready_per_filter [`DSCONV_FILTERS];
    int last_addr, last_filter;
    logic run_enable, started, done_due, finished;

    dsconv_top dsconv_top_i (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .input_pixels      (input_pixels),
        .input_pixel_addr  (input_pixel_addr),
        .output_pixel      (output_pixel),
        .output_pixel_addr (output_pixel_addr),
        .output_filter     (output_filter),
        .ready             (ready),
        .done              (done)
    );

    assign input_pixels = image[input_pixel_addr];    // Combinational image read.

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic int dw_weight(int c, int k);
        return ((3 * c + k) % 7) - 3;
    endfunction

    function automatic int pw_weight(int f, int c);
        return ((5 * f + 3 * c) % 9) - 4;
    endfunction

    function automatic int clip_pixel(int v);
        if (v > 2047) return 2047;
        if (v < -2048) return -2048;
        return v;
    endfunction

    function automatic int bn_of(int f, int x);
        return clip_pixel((x * (48 + 8 * f) + (16 * f - 32)) >>> `DSCONV_BN_SHIFT);
    endfunction

    // Returns the pointwise result after ReLU for the window ending at addr.
    function automatic int pointwise_of(int addr, int f);
        int r;
        int col;
        int a;
        int sum;
        int pw;
        r   = addr / `DSCONV_IMG_W;
        col = addr % `DSCONV_IMG_W;
        pw  = 0;
        for (int c = 0; c < `DSCONV_CHANNELS; c++) begin
            sum = 0;
            for (int k = 0; k < 9; k++) begin
                a = (r - 2 + k / 3) * `DSCONV_IMG_W + col - 2 + k % 3;
                sum += int'(image[a][c]) * dw_weight(c, k);
            end
            pw += clip_pixel(sum >>> `DSCONV_DW_SHIFT) * pw_weight(f, c);
        end
        pw = pw >>> `DSCONV_PW_SHIFT;
        return (pw < 0) ? 0 : clip_pixel(pw);
    endfunction

    // Windows lying wholly inside the full-scale negative patch.
    function automatic logic in_dark_patch(int addr);
        int r;
        int col;
        r   = addr / `DSCONV_IMG_W;
        col = addr % `DSCONV_IMG_W;
        return (r >= 4 && r <= 6 && col >= 6 && col <= 10);
    endfunction

    task automatic report_test(input string name, input int errs);
        $display("test %-10s : %s (%0d errors)", name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    // ------------------------------------------------------------------------
    // Checking and stimulus
    // ------------------------------------------------------------------------
    no_ready_with_done: assert property (@(posedge clk) disable iff (rst) !(ready && done))
        else begin
            $display("ready and done were high in the same cycle");
            err_done++;
        end

    always @(posedge clk) begin
        int   exp_pix;
        int   pw;
        logic exp_ready;
        logic exp_done;
        if (!rst) begin
            if (!started) begin
                assert (!ready && !done && output_filter == 0 && input_pixel_addr == 0
                        && output_pixel_addr == 0)
                    else begin
                        $display("Outputs left their reset values before start rose");
                        err_reset++;
                    end
                if (start) begin
                    started = 1'b1;
                    report_test("reset", err_reset);
                end
            end

            exp_ready = mp_valid[3] && (mp_addr[3] % `DSCONV_IMG_W >= 2)
                        && (mp_addr[3] / `DSCONV_IMG_W >= 2);
            checks++;
            assert (ready == exp_ready)
                else begin
                    $display("ERR framing ready expected %0d actual %0d", exp_ready, ready);
                    err_framing++;
                end
            if (exp_ready && ready) begin
                assert (int'(output_pixel_addr) == mp_addr[3]
                        && int'(output_filter) == mp_filter[3]
                        && ((int'(output_filter) == last_filter
                             && int'(output_pixel_addr) > last_addr)
                            || int'(output_filter) == last_filter + 1))
                    else begin
                        $display("ERR framing addr/filter expected %0d/%0d actual %0d/%0d",
                                 mp_addr[3], mp_filter[3], output_pixel_addr, output_filter);
                        err_framing++;
                    end
                last_addr   = int'(output_pixel_addr);
                last_filter = int'(output_filter);
                pw      = pointwise_of(mp_addr[3], mp_filter[3]);
                exp_pix = bn_of(mp_filter[3], pw);
                assert (int'(output_pixel) == exp_pix)
                    else begin
                        $display("ERR %s pixel expected %0d actual %0d",
                                 mp_gap[3] ? "start_gaps" : "values", exp_pix, output_pixel);
                        if (mp_gap[3]) err_gaps++;
                        else err_values++;
                    end
                if (in_dark_patch(mp_addr[3]) && pw == 0) begin
                    relu_hits++;
                    exp_pix = (16 * mp_filter[3] - 32) >>> `DSCONV_BN_SHIFT;
                    assert (int'(output_pixel) == exp_pix)
                        else begin
                            $display("ERR relu_bn pixel expected %0d actual %0d",
                                     exp_pix, output_pixel);
                            err_relu++;
                        end
                end
                ready_per_filter[mp_filter[3]]++;
                total_ready++;
            end

            exp_done = done_due;
            done_due = exp_ready && mp_addr[3] == PIXELS - 1
                       && mp_filter[3] == `DSCONV_FILTERS - 1;
            assert (done == exp_done)
                else begin
                    $display("ERR done expected %0d actual %0d", exp_done, done);
                    err_done++;
                end
            if (done) begin
                done_count++;
                finished = 1'b1;
            end

            // The address read by the DUT follows the pixels taken so far.
            if (start && consumed < TOTAL_PIXELS) begin
                assert (int'(input_pixel_addr) == consumed % PIXELS)
                    else begin
                        $display("ERR %s input_pixel_addr expected %0d actual %0d",
                                 (gap_runs > 0) ? "start_gaps" : "framing",
                                 consumed % PIXELS, input_pixel_addr);
                        if (gap_runs > 0) err_gaps++;
                        else err_framing++;
                    end
            end

            // Advance the model pipeline with the pixel taken at this edge.
            for (int i = 3; i > 0; i--) begin
                mp_valid[i]  = mp_valid[i-1];
                mp_addr[i]   = mp_addr[i-1];
                mp_filter[i] = mp_filter[i-1];
                mp_gap[i]    = mp_gap[i-1];
            end
            mp_valid[0]  = start && (consumed < TOTAL_PIXELS);
            mp_addr[0]   = consumed % PIXELS;
            mp_filter[0] = consumed / PIXELS;
            mp_gap[0]    = (gap_runs > 0);
            if (mp_valid[0]) consumed++;

            if (run_enable && consumed < TOTAL_PIXELS) begin
                if (gap_left > 0) begin
                    start <= 1'b0;
                    gap_left--;
                end else if (consumed >= 20 && ($random(seed) & 15) == 0) begin
                    start    <= 1'b0;
                    gap_left = {$random(seed)} % 5;    // Run of 1 to 5 idle cycles.
                    gap_runs++;
                end else begin
                    start <= 1'b1;
                end
            end else begin
                start <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int errors;
        rst = 1'b1;
        start = 1'b0;
        run_enable = 1'b0;
        started = 1'b0;
        done_due = 1'b0;
        finished = 1'b0;
        last_addr = -1;
        last_filter = 0;
        for (int i = 0; i < 4; i++) begin
            mp_valid[i] = 1'b0;
            mp_addr[i] = 0;
            mp_filter[i] = 0;
            mp_gap[i] = 1'b0;
        end
        for (int f = 0; f < `DSCONV_FILTERS; f++) ready_per_filter[f] = 0;
        for (int a = 0; a < PIXELS; a++) begin
            for (int c = 0; c < `DSCONV_CHANNELS; c++) begin
                image[a][c] = pixel_t'($random(seed));
                if (a / `DSCONV_IMG_W >= 2 && a / `DSCONV_IMG_W <= 6
                    && a % `DSCONV_IMG_W >= 4 && a % `DSCONV_IMG_W <= 10) begin
                    image[a][c] = pixel_t'(-2048);    // Full-scale negative patch.
                end
            end
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);
        run_enable <= 1'b1;

        while (!finished && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end

        if (!finished) begin
            $display("Timeout after %0d cycles without done", cycles);
            $display("*** FAILED ***");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            for (int f = 0; f < `DSCONV_FILTERS; f++) begin
                assert (ready_per_filter[f] == READY_PER_FILT)
                    else begin
                        $display("ERR framing ready count filter %0d expected %0d actual %0d",
                                 f, READY_PER_FILT, ready_per_filter[f]);
                        err_framing++;
                    end
            end
            assert (relu_hits > 0)
                else begin
                    $display("No output of the negative patch was clipped by ReLU");
                    err_relu++;
                end
            assert (gap_runs > 0)
                else begin
                    $display("The start input was never dropped during the frames");
                    err_gaps++;
                end
            assert (done_count == 1)
                else begin
                    $display("done pulsed %0d times instead of once", done_count);
                    err_done++;
                end
            report_test("framing", err_framing);
            report_test("values", err_values);
            report_test("relu_bn", err_relu);
            report_test("start_gaps", err_gaps);
            report_test("done", err_done);
            errors = err_reset + err_framing + err_values + err_relu + err_gaps + err_done;
            $display("tests 6, checks %0d, outputs %0d, errors %0d", checks, total_ready, errors);
            if (errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dsconv_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dsconv_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  dsconv_types_pkg::channel_pixels_t input_pixels,
    output dsconv_types_pkg::addr_t           input_pixel_addr,
    output dsconv_types_pkg::pixel_t          output_pixel,
    output dsconv_types_pkg::addr_t           output_pixel_addr,
    output dsconv_types_pkg::filter_t         output_filter,
    output logic                              ready,
    output logic                              done
);
    import dsconv_types_pkg::*;

    logic             pixel_valid;
    filter_t          pw_filter;
    filter_t          bn_filter;
    channel_windows_t windows;
    channel_pixels_t  dw_pixels;
    pixel_t           pw_pixel;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    dsconv_ctrl dsconv_ctrl_i (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .pixel_valid       (pixel_valid),
        .input_pixel_addr  (input_pixel_addr),
        .pw_filter         (pw_filter),
        .bn_filter         (bn_filter),
        .output_pixel_addr (output_pixel_addr),
        .output_filter     (output_filter),
        .ready             (ready),
        .done              (done)
    );

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    dsconv_line_buffer dsconv_line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .pixel_valid  (pixel_valid),
        .input_pixels (input_pixels),
        .windows      (windows)
    );

    dsconv_depthwise_pe dsconv_depthwise_pe_i (
        .clk       (clk),
        .rst       (rst),
        .windows   (windows),
        .dw_pixels (dw_pixels)
    );

    dsconv_pointwise_pe dsconv_pointwise_pe_i (
        .clk       (clk),
        .rst       (rst),
        .dw_pixels (dw_pixels),
        .pw_filter (pw_filter),
        .pw_pixel  (pw_pixel)
    );

    dsconv_batch_norm dsconv_batch_norm_i (
        .clk          (clk),
        .rst          (rst),
        .pw_pixel     (pw_pixel),
        .bn_filter    (bn_filter),
        .output_pixel (output_pixel)
    );

endmodule

`default_nettype wire

/* dsconv_batch_norm.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dsconv_config.svh"

module dsconv_batch_norm (
    input  logic                      clk,
    input  logic                      rst,
    input  dsconv_types_pkg::pixel_t  pw_pixel,
    input  dsconv_types_pkg::filter_t bn_filter,
    output dsconv_types_pkg::pixel_t  output_pixel
);
    import dsconv_types_pkg::*;
    import dsconv_coeff_pkg::*;

    acc_t scaled;

    // y = (p * x + q) >>> shift, with p and q chosen per filter.
    assign scaled = acc_t'(pw_pixel) * acc_t'(bn_scale(int'(bn_filter)))
                    + bn_offset(int'(bn_filter));

    always_ff @(posedge clk) begin
        if (rst) begin
            output_pixel <= '0;
        end else begin
            output_pixel <= saturate(scaled >>> `DSCONV_BN_SHIFT);
        end
    end

endmodule

`default_nettype wire

/* dsconv_pointwise_pe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dsconv_config.svh"

module dsconv_pointwise_pe (
    input  logic                              clk,
    input  logic                              rst,
    input  dsconv_types_pkg::channel_pixels_t dw_pixels,
    input  dsconv_types_pkg::filter_t         pw_filter,
    output dsconv_types_pkg::pixel_t          pw_pixel
);
    import dsconv_types_pkg::*;
    import dsconv_coeff_pkg::*;

    acc_t   sum;
    acc_t   shifted;
    pixel_t pw_next;

    // 1x1 convolution across the channels for the filter of this item.
    always_comb begin
        sum = '0;
        for (int c = 0; c < `DSCONV_CHANNELS; c++) begin
            sum = sum + acc_t'(dw_pixels[c]) * acc_t'(pw_coeff(int'(pw_filter), c));
        end
    end

    assign shifted = sum >>> `DSCONV_PW_SHIFT;

    always_comb begin
        if (shifted < 0) begin
            pw_next = '0;    // ReLU.
        end else begin
            pw_next = saturate(shifted);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pw_pixel <= '0;
        end else begin
            pw_pixel <= pw_next;
        end
    end

endmodule

`default_nettype wire

/* dsconv_depthwise_pe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dsconv_config.svh"

module dsconv_depthwise_pe (
    input  logic                               clk,
    input  logic                               rst,
    input  dsconv_types_pkg::channel_windows_t windows,
    output dsconv_types_pkg::channel_pixels_t  dw_pixels
);
    import dsconv_types_pkg::*;
    import dsconv_coeff_pkg::*;

    localparam int TAPS = `DSCONV_KERNEL * `DSCONV_KERNEL;

    channel_pixels_t dw_next;

    // Each channel is filtered on its own; channels never mix here.
    always_comb begin
        acc_t sum;

        for (int c = 0; c < `DSCONV_CHANNELS; c++) begin
            sum = '0;
            for (int k = 0; k < TAPS; k++) begin
                sum = sum + acc_t'(windows[c][k]) * acc_t'(dw_coeff(c, k));
            end
            dw_next[c] = saturate(sum >>> `DSCONV_DW_SHIFT);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dw_pixels <= '0;
        end else begin
            dw_pixels <= dw_next;
        end
    end

endmodule

`default_nettype wire

/* dsconv_line_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dsconv_config.svh"

module dsconv_line_buffer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pixel_valid,
    input  dsconv_types_pkg::channel_pixels_t  input_pixels,
    output dsconv_types_pkg::channel_windows_t windows
);
    import dsconv_types_pkg::*;

    localparam int K     = `DSCONV_KERNEL;
    localparam int COL_W = $clog2(`DSCONV_IMG_W);

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`DSCONV_IMG_W - 1);

    logic [COL_W-1:0] col;    // Column of the pixel being taken.

    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
        end else if (pixel_valid) begin
            col <= (col == LAST_COL) ? '0 : col + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // One pair of row memories and one window per channel
    // ------------------------------------------------------------------------
    for (genvar c = 0; c < `DSCONV_CHANNELS; c++) begin : g_channel
        pixel_t  row_above     [`DSCONV_IMG_W];
        pixel_t  row_two_above [`DSCONV_IMG_W];
        window_t win;

        always_ff @(posedge clk) begin
            if (pixel_valid) begin
                // Each column slot moves down one row as the new pixel lands.
                row_two_above[col] <= row_above[col];
                row_above[col]     <= input_pixels[c];

                for (int r = 0; r < K; r++) begin
                    for (int x = 0; x < K - 1; x++) begin
                        win[r*K + x] <= win[r*K + x + 1];
                    end
                end

                win[K-1]   <= row_two_above[col];
                win[2*K-1] <= row_above[col];
                win[3*K-1] <= input_pixels[c];    // Bottom-right tap.
            end
        end

        assign windows[c] = win;
    end

endmodule

`default_nettype wire

/* dsconv_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dsconv_config.svh"

module dsconv_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    output logic                      pixel_valid,
    output dsconv_types_pkg::addr_t   input_pixel_addr,
    output dsconv_types_pkg::filter_t pw_filter,
    output dsconv_types_pkg::filter_t bn_filter,
    output dsconv_types_pkg::addr_t   output_pixel_addr,
    output dsconv_types_pkg::filter_t output_filter,
    output logic                      ready,
    output logic                      done
);
    import dsconv_types_pkg::*;

    localparam int      TAG_DEPTH   = 4;    // Line buffer, depthwise, pointwise, batch norm.
    localparam addr_t   LAST_ADDR   = addr_t'(`DSCONV_IMG_W * `DSCONV_IMG_H - 1);
    localparam filter_t LAST_FILTER = filter_t'(`DSCONV_FILTERS - 1);

    ctrl_state_t state;
    ctrl_state_t state_next;
    filter_t     in_filter;
    item_tag_t   tags [TAG_DEPTH];
    logic        frame_end;
    logic        pipe_busy;
    int          out_col;
    int          out_row;

    // A pixel is taken in every start-high cycle while a run is open.
    assign pixel_valid = start && (state == IDLE || state == RUN);
    assign frame_end   = pixel_valid && (input_pixel_addr == LAST_ADDR);

    // The last item sitting alone in the output stage ends the drain.
    assign pipe_busy = tags[0].valid || tags[1].valid || tags[2].valid;

    // ------------------------------------------------------------------------
    // State machine and input counters
    // ------------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (start) state_next = RUN;
            RUN:     if (frame_end && in_filter == LAST_FILTER) state_next = DRAIN;
            DRAIN:   if (!pipe_busy) state_next = FINISH;
            FINISH:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= IDLE;
            input_pixel_addr <= '0;
            in_filter        <= '0;
        end else begin
            state <= state_next;
            if (pixel_valid) begin
                input_pixel_addr <= frame_end ? '0 : input_pixel_addr + 1'b1;
                if (frame_end) begin
                    in_filter <= (in_filter == LAST_FILTER) ? '0 : in_filter + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Item tags, one per pipeline stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TAG_DEPTH; i++) begin
                tags[i] <= '0;
            end
        end else begin
            tags[0] <= '{valid: pixel_valid, addr: input_pixel_addr, filter: in_filter};
            for (int i = 1; i < TAG_DEPTH; i++) begin
                tags[i] <= tags[i-1];
            end
        end
    end

    assign pw_filter = tags[1].filter;    // Item leaving the depthwise stage.
    assign bn_filter = tags[2].filter;

    assign output_pixel_addr = tags[3].addr;
    assign output_filter     = tags[3].filter;

    // Only windows lying fully inside the image are reported.
    assign out_col = int'(tags[3].addr) % `DSCONV_IMG_W;
    assign out_row = int'(tags[3].addr) / `DSCONV_IMG_W;

    assign ready = tags[3].valid && (out_col >= `DSCONV_KERNEL - 1)
                   && (out_row >= `DSCONV_KERNEL - 1);

    assign done = (state == FINISH);

endmodule

`default_nettype wire

/* dsconv_coeff_pkg.sv */
`default_nettype none

`include "dsconv_config.svh"

package dsconv_coeff_pkg;

    import dsconv_types_pkg::*;

    localparam acc_t PIXEL_MAX = acc_t'((2 ** (`DSCONV_PIXEL_W - 1)) - 1);
    localparam acc_t PIXEL_MIN = -PIXEL_MAX - acc_t'(1);

    // Depthwise weight for channel c and window tap k, in the range -3..3.
    function automatic coeff_t dw_coeff(input int c, input int k);
        return coeff_t'(((3 * c + k) % 7) - 3);
    endfunction

    // Pointwise weight of input channel c for output filter f, in the range -4..4.
    function automatic coeff_t pw_coeff(input int f, input int c);
        return coeff_t'(((5 * f + 3 * c) % 9) - 4);
    endfunction

    // Batch norm scale p.
    function automatic coeff_t bn_scale(input int f);
        return coeff_t'(48 + 8 * f);
    endfunction

    // Batch norm offset q, added to the scaled product before the shift.
    function automatic acc_t bn_offset(input int f);
        return acc_t'(16 * f - 32);
    endfunction

    // Clips an accumulator to the pixel range.
    function automatic pixel_t saturate(input acc_t value);
        if (value > PIXEL_MAX) begin
            return pixel_t'(PIXEL_MAX);
        end
        if (value < PIXEL_MIN) begin
            return pixel_t'(PIXEL_MIN);
        end
        return pixel_t'(value);
    endfunction

endpackage

`default_nettype wire

/* dsconv_types_pkg.sv */
`default_nettype none

`include "dsconv_config.svh"

package dsconv_types_pkg;

    // ------------------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------------------
    typedef logic signed [`DSCONV_PIXEL_W-1:0] pixel_t;
    typedef logic signed [`DSCONV_COEFF_W-1:0] coeff_t;
    typedef logic signed [27:0]                acc_t;    // Wide enough for 9 taps.

    typedef logic [$clog2(`DSCONV_IMG_W * `DSCONV_IMG_H)-1:0] addr_t;
    typedef logic [$clog2(`DSCONV_FILTERS)-1:0]                filter_t;

    // ------------------------------------------------------------------------
    // Grouped data
    // ------------------------------------------------------------------------
    typedef pixel_t [`DSCONV_CHANNELS-1:0] channel_pixels_t;

    // Tap 0 is the top-left pixel, taps follow in raster order.
    typedef pixel_t [`DSCONV_KERNEL*`DSCONV_KERNEL-1:0] window_t;

    typedef window_t [`DSCONV_CHANNELS-1:0] channel_windows_t;

    // Travels beside each item in the pipeline.
    typedef struct packed {
        logic    valid;
        addr_t   addr;
        filter_t filter;
    } item_tag_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

/* dsconv_config.svh */
`ifndef DSCONV_CONFIG_SVH
`define DSCONV_CONFIG_SVH

// Image and layer sizes.
`define DSCONV_CHANNELS 4
`define DSCONV_FILTERS  4
`define DSCONV_IMG_W    16
`define DSCONV_IMG_H    8
`define DSCONV_KERNEL   3

// Data widths.
`define DSCONV_PIXEL_W  12
`define DSCONV_COEFF_W  8

// Arithmetic right shifts applied after each accumulation.
`define DSCONV_DW_SHIFT 4
`define DSCONV_PW_SHIFT 4
`define DSCONV_BN_SHIFT 6

`endif
